// File: design/ramBlockPkg.sv
/* HyperRAM control block shared types */
`default_nettype none

package ramBlockPkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	// memory byte lane
	localparam int DQ_W       = 8;
	// register word on the device
	localparam int DATA_W     = 16;
	// command-address phase, six bytes
	localparam int CA_W       = 48;
	localparam int LAT_W      = 4;
	localparam int CSR_ADRS_W = 8;

	// host write side of the CSR bus
	typedef struct packed {
		logic [CSR_ADRS_W-1:0] adrs;
		logic [DATA_W-1:0]     wd;
		logic                  we;
	} csrBusT;

	// one register transaction
	// cmdAdrs[47] read, cmdAdrs[46] register space
	typedef struct packed {
		logic [CA_W-1:0]   cmdAdrs;
		logic [DATA_W-1:0] wDq;
		logic [LAT_W-1:0]  latencyCnt;
	} cfgCmdT;

	// command source tag
	typedef enum logic {
		SRC_HOST,
		SRC_CAL
	} reqSrcT;

	// engine reply, shared by both sources
	typedef struct packed {
		logic              done;
		reqSrcT            src;
		logic [DATA_W-1:0] capDq;
	} cfgRspT;

	// device pins
	typedef struct packed {
		logic [DQ_W-1:0] dq;
		logic            dqOe;
		logic            nCs;
		logic            clkEn;
	} memOutT;

	// ----------------------------------------
	// state and offset encodings
	// ----------------------------------------
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CA,
		ST_LAT,
		ST_DATA,
		ST_END
	} engStateT;

	typedef enum logic [2:0] {
		CAL_IDLE,
		CAL_ISSUE,
		CAL_WAIT,
		CAL_DONE,
		CAL_ERR
	} calStateT;

	typedef enum logic [CSR_ADRS_W-1:0] {
		CSR_CTRL   = 8'd0,
		CSR_STATUS = 8'd1,
		CSR_WDQ    = 8'd2,
		CSR_CA0    = 8'd3,
		CSR_CA1    = 8'd4,
		CSR_CA2    = 8'd5,
		CSR_LAT    = 8'd6,
		CSR_CAPDQ  = 8'd7
	} csrAdrsT;

	// register-space read, ID register at address 0
	localparam logic [CA_W-1:0] ID_REG_CA = 48'hC000_0000_0000;

endpackage

`default_nettype wire

// File: design/ramCsr.sv
/* Host CSR bank */
`timescale 1ns/100ps
`default_nettype none

module ramCsr (
	input  logic                   iSCLK,
	input  logic                   iSRST,
	input  ramBlockPkg::csrBusT    csrBus,
	output logic [15:0]            csrRd,
	output logic                   hostReq,
	output ramBlockPkg::cfgCmdT    hostCmd,
	output logic                   calStart,
	output logic                   ramRst,
	input  ramBlockPkg::cfgRspT    rsp,
	input  logic                   engBusy,
	input  logic                   calDone,
	input  logic                   calErr,
	input  logic [3:0]             calLatency
);
	import ramBlockPkg::*;

	// command fields as the host left them
	logic [DATA_W-1:0] wdqReg;
	logic [15:0]       ca0Reg;
	logic [15:0]       ca1Reg;
	logic [15:0]       ca2Reg;
	logic [LAT_W-1:0]  latReg;
	// host side bookkeeping
	logic              hostPend;
	logic [DATA_W-1:0] capReg;
	logic              hostDone;
	logic              busy;

	assign hostDone = rsp.done && (rsp.src == SRC_HOST);
	// pulse cycle counts as busy, the engine has not seen it yet
	assign busy     = hostReq | hostPend | engBusy;

	// ----------------------------------------
	// write decode
	// ----------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			wdqReg   <= '0;
			ca0Reg   <= '0;
			ca1Reg   <= '0;
			ca2Reg   <= '0;
			latReg   <= '0;
			ramRst   <= 1'b0;
			hostReq  <= 1'b0;
			calStart <= 1'b0;
		end
		else
		begin
			// strobes last one cycle
			hostReq  <= 1'b0;
			calStart <= 1'b0;
			if (csrBus.we)
			begin
				case (csrAdrsT'(csrBus.adrs))
					CSR_CTRL:
					begin
						hostReq  <= csrBus.wd[0];
						calStart <= csrBus.wd[1];
						ramRst   <= csrBus.wd[2];
					end
					CSR_WDQ: wdqReg <= csrBus.wd;
					CSR_CA0: ca0Reg <= csrBus.wd;
					CSR_CA1: ca1Reg <= csrBus.wd;
					CSR_CA2: ca2Reg <= csrBus.wd;
					CSR_LAT: latReg <= csrBus.wd[LAT_W-1:0];
					// status and capture are read only
					default: ;
				endcase
			end
		end
	end

	// pending from the pulse until the host-tagged done
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			hostPend <= 1'b0;
		else if (hostReq)
			hostPend <= 1'b1;
		else if (hostDone)
			hostPend <= 1'b0;
	end

	// keep captured word only for host reads
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			capReg <= '0;
		else if (hostDone && hostCmd.cmdAdrs[CA_W-1])
			capReg <= rsp.capDq;
	end

	// command as seen by the engine
	assign hostCmd = '{cmdAdrs: {ca2Reg, ca1Reg, ca0Reg}, wDq: wdqReg, latencyCnt: latReg};

	// ----------------------------------------
	// read mux, one cycle behind the address
	// ----------------------------------------
	always_ff @(posedge iSCLK)
	begin
		case (csrAdrsT'(csrBus.adrs))
			CSR_CTRL:   csrRd <= {13'd0, ramRst, 2'b00};
			CSR_STATUS: csrRd <= {8'd0, calLatency, 1'b0, calErr, calDone, busy};
			CSR_WDQ:    csrRd <= wdqReg;
			CSR_CA0:    csrRd <= ca0Reg;
			CSR_CA1:    csrRd <= ca1Reg;
			CSR_CA2:    csrRd <= ca2Reg;
			CSR_LAT:    csrRd <= {12'd0, latReg};
			CSR_CAPDQ:  csrRd <= capReg;
			default:    csrRd <= '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/latencyCalibrator.sv
/* Read latency calibrator */
`timescale 1ns/100ps
`default_nettype none

module latencyCalibrator #(
	parameter logic [ramBlockPkg::DATA_W-1:0] pDevId      = 16'h0C81,
	parameter int unsigned                    pMaxLatency = 15
)(
	input  logic                iSCLK,
	input  logic                iSRST,
	input  logic                calStart,
	output logic                calReq,
	output ramBlockPkg::cfgCmdT calCmd,
	input  ramBlockPkg::cfgRspT rsp,
	output logic                calDone,
	output logic                calErr,
	output logic [3:0]          calLatency
);
	import ramBlockPkg::*;

	calStateT         calState;
	// latency under test, also the result
	logic [LAT_W-1:0] latReg;
	logic             calRsp;

	// only replies tagged for us
	assign calRsp = rsp.done && (rsp.src == SRC_CAL);

	// ----------------------------------------
	// sweep sequencer
	// ----------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			calState <= CAL_IDLE;
			latReg   <= '0;
			calReq   <= 1'b0;
		end
		else
		begin
			calReq <= 1'b0;
			case (calState)
				CAL_IDLE, CAL_DONE, CAL_ERR:
				begin
					// restart from zero, old result is dropped
					if (calStart)
					begin
						latReg   <= '0;
						calState <= CAL_ISSUE;
					end
				end
				CAL_ISSUE:
				begin
					calReq   <= 1'b1;
					calState <= CAL_WAIT;
				end
				CAL_WAIT:
				begin
					if (calRsp)
					begin
						if (rsp.capDq == pDevId)
							calState <= CAL_DONE;
						else if (latReg == LAT_W'(pMaxLatency))
							calState <= CAL_ERR;
						else
						begin
							latReg   <= latReg + 1'b1;
							calState <= CAL_ISSUE;
						end
					end
				end
				default: calState <= CAL_IDLE;
			endcase
		end
	end

	// ID register read at the current latency
	assign calCmd     = '{cmdAdrs: ID_REG_CA, wDq: '0, latencyCnt: latReg};
	assign calDone    = (calState == CAL_DONE);
	assign calErr     = (calState == CAL_ERR);
	assign calLatency = latReg;

endmodule

`default_nettype wire

// File: design/hyperRamCfgEngine.sv
/* HyperRAM register transaction engine */
`timescale 1ns/100ps
`default_nettype none

module hyperRamCfgEngine (
	input  logic                iSCLK,
	input  logic                iSRST,
	input  logic                hostReq,
	input  logic                calReq,
	input  ramBlockPkg::cfgCmdT hostCmd,
	input  ramBlockPkg::cfgCmdT calCmd,
	output ramBlockPkg::cfgRspT rsp,
	output logic                engBusy,
	output ramBlockPkg::memOutT memOut,
	input  logic [7:0]          iMemDq
);
	import ramBlockPkg::*;

	localparam int CA_BYTES = CA_W / DQ_W;

	engStateT          state;
	logic              hostPend;
	logic              calPend;
	logic              hostAvail;
	logic              calAvail;
	logic              accept;
	// command and source of the running transaction
	cfgCmdT            cmdLatch;
	reqSrcT            srcLatch;
	// byte and latency counter
	logic [LAT_W-1:0]  cnt;
	logic              isRead;
	logic              lastCa;
	logic              lastLat;
	logic              lastData;
	logic [DQ_W-1:0]   caByte;
	logic [DQ_W-1:0]   wrByte;
	logic [DATA_W-1:0] capDq;

	// ----------------------------------------
	// arbitration
	// ----------------------------------------
	// a pulse in the idle cycle is taken at once
	assign hostAvail = hostPend | hostReq;
	assign calAvail  = calPend | calReq;
	assign accept    = (state == ST_IDLE) && (hostAvail || calAvail);

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			hostPend <= 1'b0;
			calPend  <= 1'b0;
		end
		else
		begin
			// host wins a tie
			if (accept && hostAvail)
				hostPend <= 1'b0;
			else if (hostReq)
				hostPend <= 1'b1;
			if (accept && !hostAvail)
				calPend <= 1'b0;
			else if (calReq)
				calPend <= 1'b1;
		end
	end

	// selected command, sampled on accept
	always_ff @(posedge iSCLK)
	begin
		if (accept)
			cmdLatch <= hostAvail ? hostCmd : calCmd;
	end

	assign isRead   = cmdLatch.cmdAdrs[CA_W-1];
	assign lastCa   = (cnt == LAT_W'(CA_BYTES - 1));
	assign lastLat  = (cnt == cmdLatch.latencyCnt - 1'b1);
	assign lastData = (cnt == LAT_W'(1));

	// ----------------------------------------
	// sequencer
	// ----------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state    <= ST_IDLE;
			srcLatch <= SRC_HOST;
			cnt      <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (accept)
					begin
						srcLatch <= hostAvail ? SRC_HOST : SRC_CAL;
						cnt      <= '0;
						state    <= ST_CA;
					end
				end
				ST_CA:
				begin
					if (lastCa)
					begin
						cnt <= '0;
						// zero latency goes straight to capture
						if (isRead && (cmdLatch.latencyCnt != '0))
							state <= ST_LAT;
						else
							state <= ST_DATA;
					end
					else
						cnt <= cnt + 1'b1;
				end
				ST_LAT:
				begin
					if (lastLat)
					begin
						cnt   <= '0;
						state <= ST_DATA;
					end
					else
						cnt <= cnt + 1'b1;
				end
				ST_DATA:
				begin
					if (lastData)
					begin
						cnt   <= '0;
						state <= ST_END;
					end
					else
						cnt <= cnt + 1'b1;
				end
				// chip select high, done out
				ST_END: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// read bytes, high byte first
	always_ff @(posedge iSCLK)
	begin
		if ((state == ST_DATA) && isRead)
			capDq <= {capDq[DATA_W-DQ_W-1:0], iMemDq};
	end

	// ----------------------------------------
	// pin drive
	// ----------------------------------------
	always_comb
	begin
		case (cnt)
			4'd0:    caByte = cmdLatch.cmdAdrs[47:40];
			4'd1:    caByte = cmdLatch.cmdAdrs[39:32];
			4'd2:    caByte = cmdLatch.cmdAdrs[31:24];
			4'd3:    caByte = cmdLatch.cmdAdrs[23:16];
			4'd4:    caByte = cmdLatch.cmdAdrs[15:8];
			4'd5:    caByte = cmdLatch.cmdAdrs[7:0];
			default: caByte = '0;
		endcase
	end

	assign wrByte = cnt[0] ? cmdLatch.wDq[DQ_W-1:0] : cmdLatch.wDq[DATA_W-1:DQ_W];

	always_comb
	begin
		memOut.nCs   = !(state inside {ST_CA, ST_LAT, ST_DATA});
		memOut.clkEn = !memOut.nCs;
		memOut.dqOe  = (state == ST_CA) || ((state == ST_DATA) && !isRead);
		if (state == ST_CA)
			memOut.dq = caByte;
		else if ((state == ST_DATA) && !isRead)
			memOut.dq = wrByte;
		else
			memOut.dq = '0;
	end

	assign rsp     = '{done: (state == ST_END), src: srcLatch, capDq: capDq};
	assign engBusy = (state != ST_IDLE);

endmodule

`default_nettype wire

// File: design/ramBlock.sv
/* HyperRAM control block top */
`timescale 1ns/100ps
`default_nettype none

module ramBlock #(
	parameter logic [ramBlockPkg::DATA_W-1:0] pDevId      = 16'h0C81,
	parameter int unsigned                    pMaxLatency = 15
)(
	input  logic                iSCLK,
	input  logic                iSRST,
	input  ramBlockPkg::csrBusT csrBus,
	output logic [15:0]         oCsrRd,
	output ramBlockPkg::memOutT memOut,
	input  logic [7:0]          iMemDq,
	output logic                oMemRstN,
	output logic                oCalDone,
	output logic                oCalErr
);
	import ramBlockPkg::*;

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	logic       hostReq;
	cfgCmdT     hostCmd;
	logic       calStart;
	logic       ramRst;
	logic       calReq;
	cfgCmdT     calCmd;
	cfgRspT     rsp;
	logic       engBusy;
	logic [3:0] calLatency;

	// host register bank
	ramCsr uCsr (
		.iSCLK(iSCLK),        .iSRST(iSRST),
		.csrBus(csrBus),      .csrRd(oCsrRd),
		.hostReq(hostReq),    .hostCmd(hostCmd),
		.calStart(calStart),  .ramRst(ramRst),
		.rsp(rsp),            .engBusy(engBusy),
		.calDone(oCalDone),   .calErr(oCalErr),
		.calLatency(calLatency)
	);

	// ID read sweep
	latencyCalibrator #(
		.pDevId(pDevId),
		.pMaxLatency(pMaxLatency)
	) uCal (
		.iSCLK(iSCLK),        .iSRST(iSRST),
		.calStart(calStart),
		.calReq(calReq),      .calCmd(calCmd),
		.rsp(rsp),
		.calDone(oCalDone),   .calErr(oCalErr),
		.calLatency(calLatency)
	);

	// shared pin sequencer
	hyperRamCfgEngine uEng (
		.iSCLK(iSCLK),        .iSRST(iSRST),
		.hostReq(hostReq),    .calReq(calReq),
		.hostCmd(hostCmd),    .calCmd(calCmd),
		.rsp(rsp),            .engBusy(engBusy),
		.memOut(memOut),      .iMemDq(iMemDq)
	);

	// device held in reset by system reset or CTRL bit2
	assign oMemRstN = ~(iSRST | ramRst);

endmodule

`default_nettype wire

// File: bench/hyperRamRegModel.sv
/* HyperRAM register space model */
`timescale 1ns/100ps
`default_nettype none

module hyperRamRegModel #(
	parameter int unsigned pLatency = 6,
	parameter logic [15:0] pDevId   = 16'h0C81
)(
	input  logic                iSCLK,
	input  logic                iSRST,
	input  ramBlockPkg::memOutT memOut,
	output logic [7:0]          dqRd
);
	import ramBlockPkg::*;

	// cycle index inside the chip select window
	logic [5:0]      kCnt;
	logic [CA_W-1:0] caReg;
	logic [7:0]      wrHi;
	logic [15:0]     cr0Reg;
	logic [15:0]     rdWord;
	logic            isRead;
	logic            isReg;

	always_ff @(posedge iSCLK)
	begin
		if (memOut.nCs)
			kCnt <= '0;
		else
			kCnt <= kCnt + 1'b1;
	end

	// six CA bytes, msb first
	always_ff @(posedge iSCLK)
	begin
		if (!memOut.nCs && (kCnt < 6'd6))
			caReg <= {caReg[CA_W-9:0], memOut.dq};
	end

	assign isRead = caReg[CA_W-1];
	assign isReg  = caReg[CA_W-2];

	// CR0 write, two bytes right after CA
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			cr0Reg <= 16'h8F1F;
		else if (!memOut.nCs && memOut.dqOe && !isRead && isReg && caReg[0])
		begin
			if (kCnt == 6'd6)
				wrHi <= memOut.dq;
			else if (kCnt == 6'd7)
				cr0Reg <= {wrHi, memOut.dq};
		end
	end

	// bit0 picks CR0, else the ID register
	assign rdWord = !isReg ? 16'h0000 : (caReg[0] ? cr0Reg : pDevId);

	// read bytes only at the fixed latency slot
	always_comb
	begin
		dqRd = '0;
		if (!memOut.nCs && isRead)
		begin
			if (kCnt == 6'(6 + pLatency))
				dqRd = rdWord[15:8];
			else if (kCnt == 6'(7 + pLatency))
				dqRd = rdWord[7:0];
		end
	end

endmodule

`default_nettype wire

// File: bench/ramBlock_assertions.sv
/* Engine pin and strobe checks */
`timescale 1ns/100ps
`default_nettype none

module ramBlock_assertions (
	input logic                iSCLK,
	input logic                iSRST,
	input ramBlockPkg::memOutT memOut,
	input logic                done
);

	// clock gate follows chip select
	assert property (@(posedge iSCLK) disable iff (iSRST) memOut.nCs == !memOut.clkEn)
		else $error("nCs and clkEn disagree");

	// no drive on the bus while deselected
	assert property (@(posedge iSCLK) disable iff (iSRST) !(memOut.dqOe && memOut.nCs))
		else $error("dqOe high with nCs high");

	// ----------------------------------------
	// single cycle done
	// ----------------------------------------
	assert property (@(posedge iSCLK) disable iff (iSRST) done |=> !done)
		else $error("done longer than one cycle");

endmodule

`default_nettype wire

// File: bench/ramBlockTb.sv
/* HyperRAM control block testbench */
`timescale 1ns/100ps
`default_nettype none

module ramBlockTb;
	import ramBlockPkg::*;

	typedef enum int {
		OP_WR, OP_RD, OP_WAIT, OP_CAL,
		OP_PINS, OP_RSTN, OP_CALDONE, OP_CALERR
	} stepOpT;

	localparam memOutT PINS_IDLE = '{dq: 8'h00, dqOe: 1'b0, nCs: 1'b1, clkEn: 1'b0};
	// host wait covers one cal transaction ahead of it
	localparam int WAIT_LIMIT = (9 + 15) * 2 + 8;
	localparam int CAL_LIMIT  = 16 * (9 + 15 + 4);

	logic        iSCLK;
	logic        iSRST;
	csrBusT      csrBus;
	logic [15:0] oCsrRd;
	memOutT      memOut;
	logic [7:0]  iMemDq;
	logic        oMemRstN;
	logic        oCalDone;
	logic        oCalErr;
	bit          tableReady;

	// stimulus table, one entry per index
	string       stepName[$];
	stepOpT      stepOp[$];
	logic [7:0]  stepAdrs[$];
	logic [15:0] stepData[$];
	logic [15:0] stepExp[$];

	ramBlock #(.pDevId(16'h0C81), .pMaxLatency(15)) UUT (
		.iSCLK(iSCLK), .iSRST(iSRST), .csrBus(csrBus), .oCsrRd(oCsrRd), .memOut(memOut),
		.iMemDq(iMemDq), .oMemRstN(oMemRstN), .oCalDone(oCalDone), .oCalErr(oCalErr)
	);

	hyperRamRegModel #(.pLatency(6)) uMem (
		.iSCLK(iSCLK), .iSRST(iSRST), .memOut(memOut), .dqRd(iMemDq)
	);

	bind hyperRamCfgEngine ramBlock_assertions uAsrt (
		.iSCLK(iSCLK), .iSRST(iSRST), .memOut(memOut), .done(rsp.done)
	);

	initial
	begin
		iSCLK = 1'b0;
		forever #50 iSCLK = ~iSCLK;
	end

	// ----------------------------------------
	// reporting and compares
	// ----------------------------------------
	task automatic abortRun(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkWord(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp)
			abortRun($sformatf("ERROR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkMem(input string name, input memOutT exp, input memOutT act);
		if (act !== exp)
			abortRun($sformatf("ERROR %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abortRun($sformatf("ERROR %s expected %b actual %b", name, exp, act));
	endtask

	// ----------------------------------------
	// bus actions
	// ----------------------------------------
	task automatic csrWrite(input logic [7:0] adrs, input logic [15:0] data);
		@(posedge iSCLK);
		csrBus <= '{adrs: adrs, wd: data, we: 1'b1};
		// write taken on this edge
		@(posedge iSCLK);
		csrBus <= '{adrs: adrs, wd: 16'h0000, we: 1'b0};
	endtask

	task automatic csrRead(input logic [7:0] adrs, output logic [15:0] data);
		@(posedge iSCLK);
		csrBus <= '{adrs: adrs, wd: 16'h0000, we: 1'b0};
		@(posedge iSCLK);
		@(negedge iSCLK);
		data = oCsrRd;
	endtask

	// poll STATUS busy, address held so csrRd tracks every cycle
	task automatic waitIdle();
		int  polls;
		bit  idle;
		polls = 0;
		idle  = 1'b0;
		@(posedge iSCLK);
		csrBus <= '{adrs: CSR_STATUS, wd: 16'h0000, we: 1'b0};
		@(posedge iSCLK);
		while (!idle)
		begin
			@(negedge iSCLK);
			if (!oCsrRd[0])
				idle = 1'b1;
			else if (polls == WAIT_LIMIT)
				abortRun("host command still busy after the wait limit");
			else
			begin
				polls++;
				@(posedge iSCLK);
			end
		end
	endtask

	task automatic waitCal(input logic [15:0] ctrl);
		int polls;
		bit ended;
		polls = 0;
		ended = 1'b0;
		csrWrite(CSR_CTRL, ctrl);
		// old result visible until the sweep restarts
		repeat (2) @(posedge iSCLK);
		while (!ended)
		begin
			@(negedge iSCLK);
			if (oCalDone || oCalErr)
				ended = 1'b1;
			else if (polls == CAL_LIMIT)
				abortRun("calibration did not end in time");
			else
			begin
				polls++;
				@(posedge iSCLK);
			end
		end
	endtask

	task automatic addStep(input string name, input stepOpT op, input logic [7:0] adrs,
	                       input logic [15:0] data, input logic [15:0] expVal);
		stepName.push_back(name);
		stepOp.push_back(op);
		stepAdrs.push_back(adrs);
		stepData.push_back(data);
		stepExp.push_back(expVal);
	endtask

	task automatic buildTable();
		logic [15:0] wrVal;
		logic [15:0] wrVal2;
		memOutT      wrLast;
		wrVal  = 16'($urandom);
		wrVal2 = 16'($urandom);
		// last write byte on the pins
		wrLast = '{dq: wrVal[7:0], dqOe: 1'b1, nCs: 1'b0, clkEn: 1'b1};
		addStep("reset pins", OP_PINS, 0, 0, 16'(PINS_IDLE));
		addStep("reset device rstN", OP_RSTN, 0, 0, 16'h0001);
		addStep("reset status", OP_RD, CSR_STATUS, 0, 16'h0000);
		addStep("reset calDone", OP_CALDONE, 0, 0, 16'h0000);
		addStep("reset calErr", OP_CALERR, 0, 0, 16'h0000);
		addStep("ramRst set", OP_WR, CSR_CTRL, 16'h0004, 0);
		addStep("device held in reset", OP_RSTN, 0, 0, 16'h0000);
		addStep("ctrl readback", OP_RD, CSR_CTRL, 0, 16'h0004);
		addStep("ramRst clear", OP_WR, CSR_CTRL, 16'h0000, 0);
		addStep("device released", OP_RSTN, 0, 0, 16'h0001);
		// CR0 write, then timing of its last byte and the end
		addStep("cr0 wdq", OP_WR, CSR_WDQ, wrVal, 0);
		addStep("cr0 ca2 write", OP_WR, CSR_CA2, 16'h6000, 0);
		addStep("cr0 ca1", OP_WR, CSR_CA1, 16'h0000, 0);
		addStep("cr0 ca0", OP_WR, CSR_CA0, 16'h0001, 0);
		addStep("lat 6", OP_WR, CSR_LAT, 16'h0006, 0);
		addStep("cr0 write go", OP_WR, CSR_CTRL, 16'h0001, 0);
		addStep("cr0 last byte at A+8", OP_PINS, 0, 16'd8, 16'(wrLast));
		addStep("cr0 idle at A+9", OP_PINS, 0, 16'd1, 16'(PINS_IDLE));
		addStep("cr0 write not busy", OP_RD, CSR_STATUS, 0, 16'h0000);
		addStep("cr0 ca2 read", OP_WR, CSR_CA2, 16'hE000, 0);
		addStep("cr0 read go", OP_WR, CSR_CTRL, 16'h0001, 0);
		addStep("cr0 read wait", OP_WAIT, 0, 0, 0);
		addStep("cr0 readback", OP_RD, CSR_CAPDQ, 0, wrVal);
		// ID reads at the right and a short latency
		addStep("id ca2", OP_WR, CSR_CA2, ID_REG_CA[47:32], 0);
		addStep("id ca1", OP_WR, CSR_CA1, ID_REG_CA[31:16], 0);
		addStep("id ca0", OP_WR, CSR_CA0, ID_REG_CA[15:0], 0);
		addStep("id read go", OP_WR, CSR_CTRL, 16'h0001, 0);
		addStep("id read wait", OP_WAIT, 0, 0, 0);
		addStep("id at lat 6", OP_RD, CSR_CAPDQ, 0, 16'h0C81);
		addStep("lat 3", OP_WR, CSR_LAT, 16'h0003, 0);
		addStep("id read lat 3 go", OP_WR, CSR_CTRL, 16'h0001, 0);
		addStep("id read lat 3 wait", OP_WAIT, 0, 0, 0);
		addStep("id at lat 3", OP_RD, CSR_CAPDQ, 0, 16'h0000);
		// calibration alone
		addStep("cal run", OP_CAL, 0, 16'h0002, 0);
		addStep("cal done", OP_CALDONE, 0, 0, 16'h0001);
		addStep("cal no err", OP_CALERR, 0, 0, 16'h0000);
		addStep("cal status", OP_RD, CSR_STATUS, 0, 16'h0062);
		// host read and calibration in one CTRL write
		addStep("both lat 6", OP_WR, CSR_LAT, 16'h0006, 0);
		addStep("both ca0", OP_WR, CSR_CA0, 16'h0001, 0);
		addStep("both ca2 write", OP_WR, CSR_CA2, 16'h6000, 0);
		addStep("both wdq", OP_WR, CSR_WDQ, wrVal2, 0);
		addStep("both cr0 write go", OP_WR, CSR_CTRL, 16'h0001, 0);
		addStep("both cr0 write wait", OP_WAIT, 0, 0, 0);
		addStep("both ca2 read", OP_WR, CSR_CA2, 16'hE000, 0);
		addStep("both cal and read", OP_CAL, 0, 16'h0003, 0);
		addStep("both host wait", OP_WAIT, 0, 0, 0);
		addStep("both host capdq", OP_RD, CSR_CAPDQ, 0, wrVal2);
		addStep("both cal status", OP_RD, CSR_STATUS, 0, 16'h0062);
		addStep("both cal no err", OP_CALERR, 0, 0, 16'h0000);
	endtask

	task automatic runStep(input int idx);
		logic [15:0] rdVal;
		case (stepOp[idx])
			OP_WR:      csrWrite(stepAdrs[idx], stepData[idx]);
			OP_RD:
			begin
				csrRead(stepAdrs[idx], rdVal);
				checkWord(stepName[idx], stepExp[idx], rdVal);
			end
			OP_WAIT:    waitIdle();
			OP_CAL:     waitCal(stepData[idx]);
			OP_PINS:
			begin
				// data field is the cycle count from the previous step
				repeat (stepData[idx]) @(posedge iSCLK);
				@(negedge iSCLK);
				checkMem(stepName[idx], memOutT'(stepExp[idx][10:0]), memOut);
			end
			OP_RSTN:
			begin
				@(negedge iSCLK);
				checkFlag(stepName[idx], stepExp[idx][0], oMemRstN);
			end
			OP_CALDONE:
			begin
				@(negedge iSCLK);
				checkFlag(stepName[idx], stepExp[idx][0], oCalDone);
			end
			OP_CALERR:
			begin
				@(negedge iSCLK);
				checkFlag(stepName[idx], stepExp[idx][0], oCalErr);
			end
			default:    abortRun("unknown step in the stimulus table");
		endcase
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		iSRST      = 1'b1;
		csrBus     = '0;
		tableReady = 1'b0;
		void'($urandom(20666));
		buildTable();
		tableReady = 1'b1;
		repeat (5) @(posedge iSCLK);
		iSRST <= 1'b0;
		for (int i = 0; i < stepName.size(); i++)
			runStep(i);
		repeat (2) @(posedge iSCLK);
		$display(">>> PASS");
		$finish;
	end

	// budget per step covers the longest read plus margin
	initial
	begin
		wait (tableReady);
		repeat (stepName.size() * (9 + 15) * 16) @(posedge iSCLK);
		abortRun("watchdog expired before the stimulus table finished");
	end

endmodule

`default_nettype wire

// File: ramBlock.f
design/ramBlockPkg.sv
design/ramCsr.sv
design/latencyCalibrator.sv
design/hyperRamCfgEngine.sv
design/ramBlock.sv
bench/hyperRamRegModel.sv
bench/ramBlock_assertions.sv
bench/ramBlockTb.sv
